// File: mandel_pkg.sv
package mandel_pkg;

	// Fraction bits of the fixed-point format
	localparam int FRAC_BITS = 23;

	// Signed Q4.23 fixed point
	typedef logic signed [26:0] fixed_t;
	typedef logic [15:0] iter_t;

	// 3-3-2 palette colour
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} color_t;

	// Top-left pixel and pixel pitch of the view
	typedef struct packed {
		fixed_t cr_origin;
		fixed_t ci_origin;
		fixed_t step;
	} view_cfg_t;

	typedef struct packed {
		iter_t count;
		logic escaped;
	} pix_result_t;

	typedef enum logic [1:0] {IT_LOAD, IT_RUN, IT_OFFER, IT_FINISHED} iter_state_t;
	typedef enum logic {WR_WAIT, WR_ACK} writer_state_t;
	typedef enum logic [1:0] {PH_ACTIVE, PH_FRONT, PH_PULSE, PH_BACK} scan_phase_t;

	// Iteration count to colour, thresholds tested high to low
	function automatic color_t colour_of(input iter_t count, input iter_t max_iter);
		color_t c;
		if (count >= max_iter) c = 8'b000_000_00;
		// Half and quarter share one colour
		else if (count >= (max_iter >> 2)) c = 8'b011_001_00;
		else if (count >= (max_iter >> 3)) c = 8'b101_010_01;
		else if (count >= (max_iter >> 4)) c = 8'b011_001_01;
		else if (count >= (max_iter >> 5)) c = 8'b001_001_01;
		else if (count >= (max_iter >> 6)) c = 8'b011_010_10;
		else c = 8'b010_100_10;
		return c;
	endfunction

endpackage

// File: mandel_iterator.sv
`timescale 1ns/1ps

module mandel_iterator #(
	parameter int IMG_W = 32,
	parameter int IMG_H = 24,
	parameter int NUM_BANKS = 2,
	parameter int MAX_ITER = 32,
	parameter int BANK_ID = 0
) (
	input  logic M10k_pll,
	input  logic reset,
	input  mandel_pkg::view_cfg_t view,
	input  logic handshake,
	output mandel_pkg::pix_result_t result,
	output logic done,
	output logic all_done
);

	localparam int ROWS = IMG_H / NUM_BANKS;
	localparam int FW = $bits(mandel_pkg::fixed_t);
	localparam int FB = mandel_pkg::FRAC_BITS;
	localparam int SW = FW + 1;
	localparam int XW = (IMG_W > 1) ? $clog2(IMG_W) : 1;
	localparam int YW = (ROWS > 1) ? $clog2(ROWS) : 1;
	localparam int FIRST_ROW = BANK_ID * ROWS;
	// Escape limits, 2 on each axis and 4 on the squared magnitude
	localparam mandel_pkg::fixed_t TWO = mandel_pkg::fixed_t'(2 << FB);
	localparam logic signed [SW-1:0] FOUR = SW'(4 << FB);

	mandel_pkg::iter_state_t state;
	logic [XW-1:0] px;
	logic [YW-1:0] py;
	// Current c, row start and pitch, all latched from the view at reset
	mandel_pkg::fixed_t cr;
	mandel_pkg::fixed_t ci;
	mandel_pkg::fixed_t cr_row;
	mandel_pkg::fixed_t step_r;
	mandel_pkg::fixed_t zr;
	mandel_pkg::fixed_t zi;
	mandel_pkg::iter_t count;
	logic signed [2*FW-1:0] zr_zr_w;
	logic signed [2*FW-1:0] zi_zi_w;
	logic signed [2*FW-1:0] zr_zi_w;
	mandel_pkg::fixed_t zr_sq;
	mandel_pkg::fixed_t zi_sq;
	mandel_pkg::fixed_t zr_zi;
	logic signed [SW-1:0] mag_sq;
	logic escape;
	logic stop;
	logic row_end;
	logic last_pix;

	// Full products, then drop FRAC_BITS
	assign zr_zr_w = zr * zr;
	assign zi_zi_w = zi * zi;
	assign zr_zi_w = zr * zi;
	assign zr_sq = zr_zr_w[FB +: FW];
	assign zi_sq = zi_zi_w[FB +: FW];
	assign zr_zi = zr_zi_w[FB +: FW];
	// One extra bit so 2^2 + 2^2 cannot wrap
	assign mag_sq = SW'(zr_sq) + SW'(zi_sq);

	// Checked on the current z before the step
	assign escape = (zr > TWO) || (zr < -TWO) || (zi > TWO) || (zi < -TWO) || (mag_sq > FOUR);
	assign stop = escape || (count >= mandel_pkg::iter_t'(MAX_ITER));
	assign row_end = (px == XW'(IMG_W - 1));
	assign last_pix = row_end && (py == YW'(ROWS - 1));

	//////////////////////////////
	// Pixel walk
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			state <= mandel_pkg::IT_LOAD;
			px <= '0;
			py <= '0;
			cr <= view.cr_origin;
			cr_row <= view.cr_origin;
			// First row of this band, counted down from the view origin
			ci <= view.ci_origin - mandel_pkg::fixed_t'(view.step * FIRST_ROW);
			step_r <= view.step;
		end else begin
			case (state)
				mandel_pkg::IT_LOAD: state <= mandel_pkg::IT_RUN;
				mandel_pkg::IT_RUN: begin
					if (stop) state <= mandel_pkg::IT_OFFER;
				end
				mandel_pkg::IT_OFFER: begin
					// Hold the result until the writer takes it
					if (handshake && last_pix) begin
						state <= mandel_pkg::IT_FINISHED;
					end else if (handshake) begin
						state <= mandel_pkg::IT_LOAD;
						if (row_end) begin
							px <= '0;
							py <= py + 1'b1;
							cr <= cr_row;
							ci <= ci - step_r;
						end else begin
							px <= px + 1'b1;
							cr <= cr + step_r;
						end
					end
				end
				// Band complete, wait here for reset
				default: state <= mandel_pkg::IT_FINISHED;
			endcase
		end
	end

	//////////////////////////////
	// z <- z^2 + c
	always_ff @(posedge M10k_pll) begin
		if (state == mandel_pkg::IT_LOAD) begin
			zr <= '0;
			zi <= '0;
			count <= '0;
		end else if (state == mandel_pkg::IT_RUN && !stop) begin
			zr <= zr_sq - zi_sq + cr;
			zi <= (zr_zi <<< 1) + ci;
			count <= count + 1'b1;
		end
	end

	// z is frozen in IT_OFFER, so escape still gives the stop reason
	assign result = '{count: count, escaped: escape};
	assign done = (state == mandel_pkg::IT_OFFER);
	assign all_done = (state == mandel_pkg::IT_FINISHED);

endmodule

// File: band_writer.sv
`timescale 1ns/1ps

module band_writer #(
	parameter int IMG_W = 32,
	parameter int IMG_H = 24,
	parameter int NUM_BANKS = 2,
	parameter int MAX_ITER = 32,
	localparam int DEPTH = IMG_W * (IMG_H / NUM_BANKS),
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
	input  logic M10k_pll,
	input  logic reset,
	input  mandel_pkg::pix_result_t result,
	input  logic done,
	input  logic all_done,
	output logic handshake,
	output logic we,
	output logic [AW-1:0] waddr,
	output mandel_pkg::color_t wdata
);

	mandel_pkg::writer_state_t state;
	// Next free address in the bank
	logic [AW-1:0] wr_ptr;
	logic take;

	// Accept a pixel only while the band is still running
	assign take = (state == mandel_pkg::WR_WAIT) && done && !all_done;

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			state <= mandel_pkg::WR_WAIT;
			handshake <= 1'b0;
			we <= 1'b0;
			wr_ptr <= '0;
		end else if (state == mandel_pkg::WR_WAIT) begin
			if (take) begin
				handshake <= 1'b1;
				we <= 1'b1;
				wr_ptr <= wr_ptr + 1'b1;
				state <= mandel_pkg::WR_ACK;
			end
		end else begin
			// Single-cycle ack and write strobe
			handshake <= 1'b0;
			we <= 1'b0;
			state <= mandel_pkg::WR_WAIT;
		end
	end

	// Address and colour ride alongside the strobe
	always_ff @(posedge M10k_pll) begin
		if (take) begin
			waddr <= wr_ptr;
			wdata <= mandel_pkg::colour_of(result.count, mandel_pkg::iter_t'(MAX_ITER));
		end
	end

endmodule

// File: pixel_bank.sv
`timescale 1ns/1ps

module pixel_bank #(
	parameter int DEPTH = 384,
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
	input  logic M10k_pll,
	input  logic we,
	input  logic [AW-1:0] waddr,
	input  mandel_pkg::color_t wdata,
	input  logic [AW-1:0] raddr,
	output mandel_pkg::color_t rdata
);

	mandel_pkg::color_t mem [DEPTH];

	// Registered read, old data on a same-address collision
	always_ff @(posedge M10k_pll) begin
		if (we) mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

// File: bank_select.sv
`timescale 1ns/1ps

module bank_select #(
	parameter int IMG_W = 32,
	parameter int IMG_H = 24,
	parameter int NUM_BANKS = 2,
	localparam int ROWS = IMG_H / NUM_BANKS,
	localparam int AW = (IMG_W * ROWS > 1) ? $clog2(IMG_W * ROWS) : 1,
	localparam int XW = (IMG_W > 1) ? $clog2(IMG_W) : 1,
	localparam int YW = (IMG_H > 1) ? $clog2(IMG_H) : 1
) (
	input  logic M10k_pll,
	input  logic [XW-1:0] next_x,
	input  logic [YW-1:0] next_y,
	output logic [AW-1:0] raddr,
	input  mandel_pkg::color_t [NUM_BANKS-1:0] bank_data,
	output mandel_pkg::color_t color
);

	localparam int BW = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

	logic [BW-1:0] bank_idx;
	logic [BW-1:0] bank_q;
	logic [YW-1:0] local_y;

	// Band of the row, then the row inside that band
	always_comb begin
		bank_idx = BW'(next_y / ROWS);
		local_y = next_y - YW'(bank_idx * ROWS);
		raddr = AW'(local_y * IMG_W + next_x);
	end

	// Select follows the one-cycle bank read
	always_ff @(posedge M10k_pll) bank_q <= bank_idx;

	assign color = bank_data[bank_q];

endmodule

// File: vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
	parameter int IMG_W = 32,
	parameter int IMG_H = 24,
	parameter int H_FRONT = 4,
	parameter int H_PULSE = 8,
	parameter int H_BACK = 4,
	parameter int V_FRONT = 2,
	parameter int V_PULSE = 2,
	parameter int V_BACK = 2,
	localparam int XW = (IMG_W > 1) ? $clog2(IMG_W) : 1,
	localparam int YW = (IMG_H > 1) ? $clog2(IMG_H) : 1
) (
	input  logic M10k_pll,
	input  logic reset,
	input  mandel_pkg::color_t color,
	output logic [XW-1:0] next_x,
	output logic [YW-1:0] next_y,
	output logic hsync,
	output logic vsync,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	output logic blank_n
);

	// Counter widths cover the longest phase
	localparam int H_CW = $clog2(IMG_W + H_FRONT + H_PULSE + H_BACK + 4);
	localparam int V_CW = $clog2(IMG_H + V_FRONT + V_PULSE + V_BACK + 3);

	mandel_pkg::scan_phase_t h_phase;
	mandel_pkg::scan_phase_t v_phase;
	logic [H_CW-1:0] h_cnt;
	logic [V_CW-1:0] v_cnt;
	logic h_end;
	logic v_end;
	logic line_done;
	// Stage one of the two-cycle output pipe
	logic act_d1;
	logic hs_d1;
	logic vs_d1;

	function automatic mandel_pkg::scan_phase_t next_phase(input mandel_pkg::scan_phase_t p);
		case (p)
			mandel_pkg::PH_ACTIVE: return mandel_pkg::PH_FRONT;
			mandel_pkg::PH_FRONT: return mandel_pkg::PH_PULSE;
			mandel_pkg::PH_PULSE: return mandel_pkg::PH_BACK;
			default: return mandel_pkg::PH_ACTIVE;
		endcase
	endfunction

	// Cycles per phase, front porch also takes the wrap cycle
	function automatic int h_len(input mandel_pkg::scan_phase_t p);
		case (p)
			mandel_pkg::PH_ACTIVE: return IMG_W;
			mandel_pkg::PH_FRONT: return H_FRONT + 2;
			mandel_pkg::PH_PULSE: return H_PULSE + 1;
			default: return H_BACK + 1;
		endcase
	endfunction

	// Lines per phase
	function automatic int v_len(input mandel_pkg::scan_phase_t p);
		case (p)
			mandel_pkg::PH_ACTIVE: return IMG_H;
			mandel_pkg::PH_FRONT: return V_FRONT + 1;
			mandel_pkg::PH_PULSE: return V_PULSE + 1;
			default: return V_BACK + 1;
		endcase
	endfunction

	assign h_end = (h_cnt == H_CW'(h_len(h_phase) - 1));
	assign v_end = (v_cnt == V_CW'(v_len(v_phase) - 1));
	// Last back-porch cycle ends the line
	assign line_done = h_end && (h_phase == mandel_pkg::PH_BACK);

	//////////////////////////////
	// Horizontal and vertical
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			h_phase <= mandel_pkg::PH_ACTIVE;
			h_cnt <= '0;
		end else if (h_end) begin
			h_phase <= next_phase(h_phase);
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			v_phase <= mandel_pkg::PH_ACTIVE;
			v_cnt <= '0;
		end else if (line_done && v_end) begin
			v_phase <= next_phase(v_phase);
			v_cnt <= '0;
		end else if (line_done) begin
			v_cnt <= v_cnt + 1'b1;
		end
	end

	// Read coordinate for the pixel two cycles ahead
	assign next_x = (h_phase == mandel_pkg::PH_ACTIVE) ? XW'(h_cnt) : '0;
	assign next_y = (v_phase == mandel_pkg::PH_ACTIVE) ? YW'(v_cnt) : '0;

	//////////////////////////////
	// Output pipe
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			act_d1 <= 1'b0;
			hs_d1 <= 1'b1;
			vs_d1 <= 1'b1;
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank_n <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			act_d1 <= (h_phase == mandel_pkg::PH_ACTIVE) && (v_phase == mandel_pkg::PH_ACTIVE);
			hs_d1 <= (h_phase != mandel_pkg::PH_PULSE);
			vs_d1 <= (v_phase != mandel_pkg::PH_PULSE);
			// Syncs delayed to line up with the colour
			hsync <= hs_d1;
			vsync <= vs_d1;
			blank_n <= act_d1;
			// Zero-fill low bits, black outside the active area
			red <= act_d1 ? {color.red, 5'd0} : 8'd0;
			green <= act_d1 ? {color.green, 5'd0} : 8'd0;
			blue <= act_d1 ? {color.blue, 6'd0} : 8'd0;
		end
	end

endmodule

// File: mandel_top.sv
`timescale 1ns/1ps

module mandel_top #(
	parameter int IMG_W = 32,
	parameter int IMG_H = 24,
	parameter int NUM_BANKS = 2,
	parameter int MAX_ITER = 32,
	parameter int H_FRONT = 4,
	parameter int H_PULSE = 8,
	parameter int H_BACK = 4,
	parameter int V_FRONT = 2,
	parameter int V_PULSE = 2,
	parameter int V_BACK = 2
) (
	input  logic M10k_pll,
	input  logic reset,
	input  mandel_pkg::view_cfg_t view,
	output logic render_done,
	output logic hsync,
	output logic vsync,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	output logic blank_n
);

	localparam int ROWS = IMG_H / NUM_BANKS;
	localparam int DEPTH = IMG_W * ROWS;
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int XW = (IMG_W > 1) ? $clog2(IMG_W) : 1;
	localparam int YW = (IMG_H > 1) ? $clog2(IMG_H) : 1;

	// Per-band handshake and write side
	mandel_pkg::pix_result_t result [NUM_BANKS];
	logic [NUM_BANKS-1:0] done;
	logic [NUM_BANKS-1:0] all_done;
	logic [NUM_BANKS-1:0] handshake;
	logic [NUM_BANKS-1:0] we;
	logic [AW-1:0] waddr [NUM_BANKS];
	mandel_pkg::color_t wdata [NUM_BANKS];
	// Shared read side
	mandel_pkg::color_t [NUM_BANKS-1:0] bank_data;
	logic [AW-1:0] raddr;
	logic [XW-1:0] next_x;
	logic [YW-1:0] next_y;
	mandel_pkg::color_t color;
	logic disp_reset;

	//////////////////////////////
	// One iterator, writer and bank per band
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_band
		mandel_iterator #(
			.IMG_W(IMG_W), .IMG_H(IMG_H), .NUM_BANKS(NUM_BANKS),
			.MAX_ITER(MAX_ITER), .BANK_ID(b)
		) u_iter (
			.M10k_pll(M10k_pll), .reset(reset), .view(view), .handshake(handshake[b]),
			.result(result[b]), .done(done[b]), .all_done(all_done[b])
		);

		band_writer #(
			.IMG_W(IMG_W), .IMG_H(IMG_H), .NUM_BANKS(NUM_BANKS), .MAX_ITER(MAX_ITER)
		) u_writer (
			.M10k_pll(M10k_pll), .reset(reset), .result(result[b]), .done(done[b]),
			.all_done(all_done[b]), .handshake(handshake[b]), .we(we[b]),
			.waddr(waddr[b]), .wdata(wdata[b])
		);

		pixel_bank #(.DEPTH(DEPTH)) u_bank (
			.M10k_pll(M10k_pll), .we(we[b]), .waddr(waddr[b]), .wdata(wdata[b]),
			.raddr(raddr), .rdata(bank_data[b])
		);
	end

	// Every band finished
	always_ff @(posedge M10k_pll) begin
		if (reset) render_done <= 1'b0;
		else render_done <= &all_done;
	end

	// Display waits in reset until the whole frame is in memory
	assign disp_reset = reset | ~render_done;

	bank_select #(.IMG_W(IMG_W), .IMG_H(IMG_H), .NUM_BANKS(NUM_BANKS)) u_sel (
		.M10k_pll(M10k_pll), .next_x(next_x), .next_y(next_y), .raddr(raddr),
		.bank_data(bank_data), .color(color)
	);

	vga_timing #(
		.IMG_W(IMG_W), .IMG_H(IMG_H), .H_FRONT(H_FRONT), .H_PULSE(H_PULSE), .H_BACK(H_BACK),
		.V_FRONT(V_FRONT), .V_PULSE(V_PULSE), .V_BACK(V_BACK)
	) u_vga (
		.M10k_pll(M10k_pll), .reset(disp_reset), .color(color), .next_x(next_x),
		.next_y(next_y), .hsync(hsync), .vsync(vsync), .red(red), .green(green),
		.blue(blue), .blank_n(blank_n)
	);

endmodule

// File: tb_mandel.sv
`timescale 1ns/1ps

module tb_mandel;

	localparam int IMG_W = 32;
	localparam int IMG_H = 24;
	localparam int NUM_BANKS = 2;
	localparam int MAX_ITER = 32;
	localparam int H_FRONT = 4;
	localparam int H_PULSE = 8;
	localparam int H_BACK = 4;
	localparam int V_FRONT = 2;
	localparam int V_PULSE = 2;
	localparam int V_BACK = 2;
	localparam int NPIX = IMG_W * IMG_H;
	localparam int LINE_LEN = IMG_W + H_FRONT + H_PULSE + H_BACK + 4;
	localparam int NUM_TESTS = 5;
	localparam int TEST_LIMIT = 40000;
	localparam int RUN_LIMIT = TEST_LIMIT * NUM_TESTS;
	// Q4.23 constants
	localparam int ONE = 1 << 23;
	localparam mandel_pkg::fixed_t TWO = 27'sd16777216;
	localparam logic signed [27:0] FOUR = 28'sd33554432;

	logic M10k_pll;
	logic reset;
	mandel_pkg::view_cfg_t view;
	logic render_done;
	logic hsync;
	logic vsync;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	logic blank_n;

	// Expected RGB per pixel, raster order
	logic [23:0] exp_rgb [NPIX];
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int t;

	mandel_top #(
		.IMG_W(IMG_W), .IMG_H(IMG_H), .NUM_BANKS(NUM_BANKS), .MAX_ITER(MAX_ITER),
		.H_FRONT(H_FRONT), .H_PULSE(H_PULSE), .H_BACK(H_BACK),
		.V_FRONT(V_FRONT), .V_PULSE(V_PULSE), .V_BACK(V_BACK)
	) i_dut (
		.M10k_pll(M10k_pll), .reset(reset), .view(view), .render_done(render_done),
		.hsync(hsync), .vsync(vsync), .red(red), .green(green), .blue(blue),
		.blank_n(blank_n)
	);

	initial begin
		M10k_pll = 1'b0;
		forever #20 M10k_pll = ~M10k_pll;
	end

	// Hard stop for the whole run
	always @(posedge M10k_pll) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= RUN_LIMIT) begin
			$display("timeout: run went past %0d cycles", RUN_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Reference model

	// Iterations until escape, or MAX_ITER
	function automatic int escape_count(input mandel_pkg::fixed_t cr, input mandel_pkg::fixed_t ci);
		logic signed [53:0] wr;
		logic signed [53:0] wi;
		mandel_pkg::fixed_t zr;
		mandel_pkg::fixed_t zi;
		mandel_pkg::fixed_t rr;
		mandel_pkg::fixed_t ii;
		mandel_pkg::fixed_t ri;
		logic signed [27:0] mag;
		int n;
		zr = '0;
		zi = '0;
		for (n = 0; n < MAX_ITER; n++) begin
			wr = 54'(zr);
			wi = 54'(zi);
			// Products truncated by an arithmetic shift of 23
			rr = mandel_pkg::fixed_t'((wr * wr) >>> 23);
			ii = mandel_pkg::fixed_t'((wi * wi) >>> 23);
			ri = mandel_pkg::fixed_t'((wr * wi) >>> 23);
			mag = 28'(rr) + 28'(ii);
			if (zr > TWO || zr < -TWO || zi > TWO || zi < -TWO || mag > FOUR) return n;
			zr = rr - ii + cr;
			zi = (ri <<< 1) + ci;
		end
		return MAX_ITER;
	endfunction

	// Palette thresholds, highest first
	function automatic logic [7:0] palette_color(input int n);
		if (n >= MAX_ITER) return 8'b000_000_00;
		if (n >= (MAX_ITER >> 1)) return 8'b011_001_00;
		if (n >= (MAX_ITER >> 2)) return 8'b011_001_00;
		if (n >= (MAX_ITER >> 3)) return 8'b101_010_01;
		if (n >= (MAX_ITER >> 4)) return 8'b011_001_01;
		if (n >= (MAX_ITER >> 5)) return 8'b001_001_01;
		if (n >= (MAX_ITER >> 6)) return 8'b011_010_10;
		return 8'b010_100_10;
	endfunction

	task automatic build_frame(input mandel_pkg::view_cfg_t v, output int blacks);
		int x;
		int y;
		int n;
		logic [7:0] c;
		mandel_pkg::fixed_t cr;
		mandel_pkg::fixed_t ci;
		blacks = 0;
		for (y = 0; y < IMG_H; y++) begin
			// Down one row subtracts a step from the imaginary part
			ci = mandel_pkg::fixed_t'(int'(v.ci_origin) - int'(v.step) * y);
			for (x = 0; x < IMG_W; x++) begin
				cr = mandel_pkg::fixed_t'(int'(v.cr_origin) + int'(v.step) * x);
				n = escape_count(cr, ci);
				if (n >= MAX_ITER) blacks++;
				c = palette_color(n);
				// Zero-filled low bits per channel
				exp_rgb[y * IMG_W + x] = {c[7:5], 5'd0, c[4:2], 5'd0, c[1:0], 6'd0};
			end
		end
	endtask

	// cr in [-2,-1], ci in [0.5,1.2], step in [1/64,1/16]
	task automatic draw_view(output mandel_pkg::view_cfg_t v);
		v.cr_origin = mandel_pkg::fixed_t'(-2 * ONE + int'($urandom % ONE));
		v.ci_origin = mandel_pkg::fixed_t'(ONE / 2 + int'($urandom % (ONE * 7 / 10 + 1)));
		v.step = mandel_pkg::fixed_t'(ONE / 64 + int'($urandom % (ONE / 16 - ONE / 64 + 1)));
	endtask

	//////////////////////////////
	// One reset, render and frame
	task automatic run_test(input int tn);
		mandel_pkg::view_cfg_t v;
		int blacks;
		int tries;
		int errs;
		int i;
		int waited;
		int pix;
		int cyc;
		int last_fall;
		int falls;
		int h_low;
		int v_low;
		int v_runs;
		logic idle_bad;
		logic drop_seen;
		logic prev_hs;
		logic prev_vs;
		logic [23:0] got;
		errs = 0;
		blacks = 0;
		tries = 0;
		idle_bad = 1'b0;
		drop_seen = 1'b0;
		// Redraw until the view holds some MAX_ITER pixels
		while (blacks == 0 && tries < 64) begin
			draw_view(v);
			build_frame(v, blacks);
			tries++;
		end
		@(negedge M10k_pll);
		reset = 1'b1;
		view = v;
		for (i = 0; i < 16; i++) begin
			@(negedge M10k_pll);
			if (render_done !== 1'b0 || blank_n !== 1'b0 || hsync !== 1'b1 || vsync !== 1'b1) begin
				if (!idle_bad) $display("test%0d: outputs not idle during reset", tn);
				idle_bad = 1'b1;
				errs++;
			end
		end
		reset = 1'b0;
		// Display stays quiet until render_done
		waited = 0;
		while (render_done !== 1'b1 && waited < TEST_LIMIT) begin
			@(negedge M10k_pll);
			waited++;
			if (render_done !== 1'b1 && (blank_n !== 1'b0 || hsync !== 1'b1 || vsync !== 1'b1)) begin
				if (!idle_bad) $display("test%0d: display active before render_done", tn);
				idle_bad = 1'b1;
				errs++;
			end
		end
		if (render_done !== 1'b1) begin
			$display("test%0d: render_done did not rise within %0d cycles", tn, TEST_LIMIT);
			errs++;
		end else begin
			pix = 0;
			cyc = 0;
			last_fall = -1;
			falls = 0;
			h_low = 0;
			v_low = 0;
			v_runs = 0;
			prev_hs = hsync;
			prev_vs = vsync;
			// Run until the frame, one vsync pulse and three hsync falls are seen
			while ((pix < NPIX || v_runs == 0 || falls < 3) && cyc < TEST_LIMIT) begin
				@(negedge M10k_pll);
				cyc++;
				if (render_done !== 1'b1 && !drop_seen) begin
					$display("test%0d: render_done dropped during the frame", tn);
					drop_seen = 1'b1;
					errs++;
				end
				if (blank_n === 1'b1 && pix < NPIX) begin
					got = {red, green, blue};
					if (got !== exp_rgb[pix]) begin
						errs++;
						if (errs <= 8) begin
							$display("error test%0d pixel %0d expected %06h actual %06h",
								tn, pix, exp_rgb[pix], got);
						end
					end
					pix++;
				end
				// Line period between falling edges
				if (!hsync) h_low++;
				if (prev_hs && !hsync) begin
					if (last_fall >= 0 && cyc - last_fall != LINE_LEN) begin
						$display("error test%0d hsync period expected %0d actual %0d",
							tn, LINE_LEN, cyc - last_fall);
						errs++;
					end
					last_fall = cyc;
					falls++;
				end
				if (!prev_hs && hsync) begin
					if (h_low != H_PULSE + 1) begin
						$display("error test%0d hsync low expected %0d actual %0d",
							tn, H_PULSE + 1, h_low);
						errs++;
					end
					h_low = 0;
				end
				// Vertical pulse counted in whole lines
				if (!vsync) v_low++;
				if (!prev_vs && vsync) begin
					if (v_low != (V_PULSE + 1) * LINE_LEN) begin
						$display("error test%0d vsync low expected %0d actual %0d",
							tn, (V_PULSE + 1) * LINE_LEN, v_low);
						errs++;
					end
					v_low = 0;
					v_runs++;
				end
				prev_hs = hsync;
				prev_vs = vsync;
			end
			if (pix < NPIX) begin
				$display("test%0d: only %0d of %0d pixels were shown", tn, pix, NPIX);
				errs++;
			end
			if (v_runs == 0) begin
				$display("test%0d: no complete vsync pulse was seen", tn);
				errs++;
			end
		end
		if (errs == 0) pass_count++;
		else fail_count++;
		$display("test%0d cr=%h ci=%h step=%h black=%0d errors=%0d %s", tn, v.cr_origin,
			v.ci_origin, v.step, blacks, errs, (errs == 0) ? "ok" : "failed");
	endtask

	initial begin
		void'($urandom(32'h57d));
		reset = 1'b1;
		view = '0;
		for (t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: sim.f
mandel_pkg.sv
mandel_iterator.sv
band_writer.sv
pixel_bank.sv
bank_select.sv
vga_timing.sv
mandel_top.sv
tb_mandel.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --top-module tb_mandel -f sim.f -o tb_mandel_sim > build.log 2>&1 \
	&& ./obj_dir/tb_mandel_sim > sim.log 2>&1 \
	|| echo "build or simulation stopped early"

cat build.log sim.log 2>/dev/null
grep -q "STATUS: PASS" sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
